// ==== project.f ====
source/bus_pkg.sv
source/map_pkg.sv
source/cpu_bus.sv
source/bus_decoder.sv
source/word_ram.sv
source/tick_timer.sv
source/soc_top.sv
tests/tb_clock.sv
tests/soc_assert.sv
tests/soc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compiles the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module soc_tb -f project.f --Mdir obj_dir -o soc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/soc_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
  exit 0
fi
exit 1

// ==== tests/soc_tb.sv ====
// Drives the CPU port from a table whose expected values come from a
// reference word memory, then runs the timer interrupt sequence.
`timescale 1ns/1ps

module soc_tb
  import bus_pkg::*;
  import map_pkg::*;
();

  localparam int RAM_WORDS     = 256;
  localparam int TIMER_IRQ     = 3;
  localparam int TIMER_DIVISOR = 8;
  localparam int ACCESS_LIMIT  = 8;

  typedef struct packed {
    logic         idle;
    logic         we;
    access_size_t size;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [31:0]  exp;
  } entry_t;

  logic                 clk;
  logic                 rst;
  cpu_req_t             cpu_req;
  cpu_rsp_t             cpu_rsp;
  logic [IRQ_LINES-1:0] cpu_irq;
  logic                 ack_seen;
  logic [31:0]          rdata_seen;
  int                   ack_total = 0;

  entry_t      stim[$];
  logic [31:0] ref_mem [RAM_WORDS];
  logic [31:0] ref_divisor;
  int          checks;
  int          errors;
  int          accesses;
  int          assert_fails;
  int          watchdog_cycles = 0;

  tb_clock #(.PERIOD_NS(100)) tb_clock_i (.clk(clk));

  soc_top #(
    .RAM_WORDS (RAM_WORDS),
    .TIMER_IRQ (TIMER_IRQ)
  ) soc_top_i (
    .clk     (clk),
    .rst     (rst),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .cpu_irq (cpu_irq)
  );

  // response as it stood at each rising edge
  always @(posedge clk) begin
    ack_seen   <= cpu_rsp.ack;
    rdata_seen <= cpu_rsp.rdata;
    if (cpu_rsp.ack) begin
      ack_total <= ack_total + 1;
    end
  end

  function automatic region_t region_for(logic [31:0] addr);
    case (addr[31:28])
      4'h0:    return REGION_RAM;
      4'hf:    return REGION_TIMER;
      default: return REGION_NONE;
    endcase
  endfunction

  function automatic int ram_index(logic [31:0] addr);
    return int'(addr >> 2) % RAM_WORDS;
  endfunction

  // timer stays disabled while the table runs
  function automatic logic [31:0] ref_word(logic [31:0] addr);
    case (region_for(addr))
      REGION_RAM:   return ref_mem[ram_index(addr)];
      REGION_TIMER: return (addr[3:2] == 2'd1) ? ref_divisor : 32'h0;
      default:      return 32'h0;
    endcase
  endfunction

  // big-endian, offset 0 is the top lane
  function automatic int lane_shift(access_size_t size, logic [31:0] addr);
    case (size)
      SIZE_BYTE: return 8 * (3 - int'(addr[1:0]));
      SIZE_HALF: return 16 * (1 - int'(addr[1]));
      default:   return 0;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(access_size_t size);
    case (size)
      SIZE_BYTE: return 32'h0000_00ff;
      SIZE_HALF: return 32'h0000_ffff;
      default:   return 32'hffff_ffff;
    endcase
  endfunction

  function automatic entry_t make_entry(logic idle, logic we, access_size_t size,
                                        logic [31:0] addr, logic [31:0] wdata,
                                        logic [31:0] exp);
    return '{idle: idle, we: we, size: size, addr: addr, wdata: wdata, exp: exp};
  endfunction

  function automatic void add_write(access_size_t size, logic [31:0] addr,
                                    logic [31:0] wdata, logic idle);
    int          sh;
    logic [31:0] mask;
    logic [31:0] word;
    sh   = lane_shift(size, addr);
    mask = lane_mask(size) << sh;
    word = (ref_word(addr) & ~mask) | ((wdata << sh) & mask);
    if (region_for(addr) == REGION_RAM) begin
      ref_mem[ram_index(addr)] = word;
    end else if (region_for(addr) == REGION_TIMER && addr[3:2] == 2'd1) begin
      ref_divisor = word;
    end
    stim.push_back(make_entry(idle, 1'b1, size, addr, wdata, 32'h0));
  endfunction

  function automatic void add_read(access_size_t size, logic [31:0] addr, logic idle);
    logic [31:0] exp;
    exp = (ref_word(addr) >> lane_shift(size, addr)) & lane_mask(size);
    stim.push_back(make_entry(idle, 1'b0, size, addr, $urandom, exp));
  endfunction

  function automatic void build_stim();
    for (int i = 0; i < 8; i++) begin
      add_write(SIZE_WORD, 32'(4 * i), $urandom, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      add_read(SIZE_WORD, 32'(4 * i), i == 3);
    end
    // aliases one RAM size apart
    add_write(SIZE_WORD, 32'h0000_0420, $urandom, 1'b1);
    add_read(SIZE_WORD, 32'h0000_0020, 1'b0);
    add_write(SIZE_WORD, 32'h0000_0024, $urandom, 1'b0);
    add_read(SIZE_WORD, 32'h0000_1024, 1'b0);
    for (int off = 0; off < 4; off++) begin
      add_write(SIZE_BYTE, 32'h10 + 32'(off), $urandom, 1'b0);
      add_read(SIZE_WORD, 32'h10, 1'b0);
    end
    add_write(SIZE_HALF, 32'h14, $urandom, 1'b0);
    add_write(SIZE_HALF, 32'h16, $urandom, 1'b1);
    add_read(SIZE_WORD, 32'h14, 1'b0);
    for (int off = 0; off < 4; off++) begin
      add_read(SIZE_BYTE, 32'h08 + 32'(off), 1'b0);
    end
    add_read(SIZE_HALF, 32'h0c, 1'b0);
    add_read(SIZE_HALF, 32'h0e, 1'b1);
    // unmapped, index 1 must keep its data
    add_read(SIZE_WORD, 32'h4000_0000, 1'b0);
    add_write(SIZE_WORD, 32'h4000_0004, $urandom, 1'b0);
    add_write(SIZE_BYTE, 32'h8000_0005, $urandom, 1'b0);
    add_read(SIZE_HALF, 32'h7000_0006, 1'b0);
    add_read(SIZE_WORD, 32'h0000_0004, 1'b0);
    add_write(SIZE_WORD, 32'hf000_0004, 32'habcd_1234, 1'b0);
    add_write(SIZE_HALF, 32'hf000_0006, 32'(TIMER_DIVISOR), 1'b0);
    add_read(SIZE_WORD, 32'hf000_0004, 1'b0);
    add_write(SIZE_HALF, 32'hf000_0004, 32'h0, 1'b1);
    add_read(SIZE_BYTE, 32'hf000_0007, 1'b0);
    add_read(SIZE_WORD, 32'hf000_0004, 1'b0);
    add_read(SIZE_WORD, 32'hf000_000c, 1'b0);
  endfunction

  function automatic int latency_bound(entry_t e);
    int base;
    base = (region_for(e.addr) == REGION_RAM) ? 2 : 1;
    if (e.we && e.size != SIZE_WORD) begin
      return 2 * base;
    end
    return base;
  endfunction

  // starts and ends on a falling edge
  task automatic apply_entry(entry_t e);
    logic        acked;
    logic [31:0] rdata;
    int          cycles;
    acked  = 1'b0;
    rdata  = 32'h0;
    cycles = 0;
    if (e.idle) begin
      cpu_req.stb = 1'b0;
      @(negedge clk);
    end
    cpu_req = '{stb: 1'b1, we: e.we, size: e.size, addr: e.addr, wdata: e.wdata};
    while (!acked && cycles < ACCESS_LIMIT) begin
      @(negedge clk);
      cycles++;
      acked = ack_seen;
      rdata = rdata_seen;
    end
    accesses++;
    checks++;
    assert (acked && cycles <= latency_bound(e)) else begin
      $display("access to %h got no acknowledge within %0d cycles",
               e.addr, latency_bound(e));
      errors++;
    end
    if (!e.we) begin
      checks++;
      assert (rdata === e.exp) else begin
        $display("mismatch at %0t: %s read of %h returned %h, expected %h",
                 $time, e.size.name(), e.addr, rdata, e.exp);
        errors++;
      end
    end
  endtask

  task automatic run_timer_irq();
    int                   waited;
    logic [IRQ_LINES-1:0] others;
    waited = 0;
    apply_entry(make_entry(1'b0, 1'b1, SIZE_WORD, 32'hf000_0000, 32'h3, 32'h0));
    cpu_req.stb = 1'b0;
    while (!cpu_irq[TIMER_IRQ] && waited < TIMER_DIVISOR + 4) begin
      @(negedge clk);
      waited++;
    end
    others = cpu_irq;
    others[TIMER_IRQ] = 1'b0;
    checks += 2;
    assert (cpu_irq[TIMER_IRQ]) else begin
      $display("timer interrupt did not rise within %0d cycles", TIMER_DIVISOR + 4);
      errors++;
    end
    assert (others == '0) else begin
      $display("mismatch at %0t: interrupt lines %h, expected only line %0d",
               $time, cpu_irq, TIMER_IRQ);
      errors++;
    end
    apply_entry(make_entry(1'b0, 1'b0, SIZE_WORD, 32'hf000_000c, 32'h0, 32'h1));
    apply_entry(make_entry(1'b0, 1'b1, SIZE_WORD, 32'hf000_000c, 32'h1, 32'h0));
    checks++;
    assert (!cpu_irq[TIMER_IRQ]) else begin
      $display("timer interrupt stayed high after the status clear");
      errors++;
    end
    apply_entry(make_entry(1'b0, 1'b1, SIZE_WORD, 32'hf000_0000, 32'h0, 32'h0));
    apply_entry(make_entry(1'b0, 1'b0, SIZE_WORD, 32'hf000_000c, 32'h0, 32'h0));
    cpu_req.stb = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    rst         = 1'b1;
    cpu_req     = '0;
    checks      = 0;
    errors      = 0;
    accesses    = 0;
    ref_divisor = 32'h0;
    void'($urandom(28));
    build_stim();
    // table plus reset, timer wait and the interrupt sequence
    watchdog_cycles = stim.size() * 10 + TIMER_DIVISOR + 4 + 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end
    run_timer_irq();
    checks++;
    assert (ack_total == accesses) else begin
      $display("mismatch at %0t: %0d acknowledges for %0d accesses",
               $time, ack_total, accesses);
      errors++;
    end
    assert_fails = soc_top_i.cpu_bus_i.soc_assert_i.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("run timed out after %0d cycles, checks %0d, errors %0d",
             watchdog_cycles, checks, errors);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== tests/soc_assert.sv ====
// Protocol checks bound into cpu_bus. The write-back check assumes the CPU
// holds size and address until its ack.
`timescale 1ns/1ps

module soc_assert
  import bus_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input cpu_req_t cpu_req,
  input cpu_rsp_t cpu_rsp,
  input bus_req_t bus_req,
  input bus_rsp_t bus_rsp,
  input logic     write_back
);

  int          fail_count = 0;
  logic        sub_write;
  logic [31:0] keep_mask;
  logic [31:0] read_word;

  assign sub_write = cpu_req.stb && cpu_req.we && (cpu_req.size != SIZE_WORD);

  // lanes the sub-word write must leave alone
  always_comb begin
    if (cpu_req.size == SIZE_BYTE) begin
      keep_mask = ~(32'hff00_0000 >> {cpu_req.addr[1:0], 3'b000});
    end else begin
      keep_mask = ~(32'hffff_0000 >> {cpu_req.addr[1], 4'b0000});
    end
  end

  // word returned by the read phase
  always_ff @(posedge clk) begin
    if (!write_back) begin
      read_word <= bus_rsp.rdata;
    end
  end

  ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
    cpu_rsp.ack |-> cpu_req.stb)
    else begin
      $error("cpu ack raised without cpu stb");
      fail_count++;
    end

  // write-back writes the read word with only the new lane changed
  write_back_is_write: assert property (@(posedge clk) disable iff (rst)
    write_back |-> (bus_req.stb && bus_req.we &&
                    (((bus_req.wdata ^ read_word) & keep_mask) == '0)))
    else begin
      $error("bus write-back is not a write of the merged word");
      fail_count++;
    end

  sub_write_holds_stb: assert property (@(posedge clk) disable iff (rst)
    sub_write |-> bus_req.stb)
    else begin
      $error("bus stb dropped during a sub-word write");
      fail_count++;
    end

endmodule

bind cpu_bus soc_assert soc_assert_i (
  .clk        (clk),
  .rst        (rst),
  .cpu_req    (cpu_req),
  .cpu_rsp    (cpu_rsp),
  .bus_req    (bus_req),
  .bus_rsp    (bus_rsp),
  .write_back (state == WRITE_BACK)
);

// ==== tests/tb_clock.sv ====
// Free-running testbench clock, starts low.
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2);
    clk = ~clk;
  end

endmodule

// ==== source/soc_top.sv ====
// Bus subsystem top. The CPU port is the outside interface; one master,
// no caches and no bus errors.
`timescale 1ns/1ps

module soc_top
  import bus_pkg::*;
#(
  parameter int RAM_WORDS = 256,
  parameter int TIMER_IRQ = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_req_t             cpu_req,
  output cpu_rsp_t             cpu_rsp,
  output logic [IRQ_LINES-1:0] cpu_irq
);

  bus_req_t             bus_req;
  bus_rsp_t             bus_rsp;
  bus_req_t             ram_req;
  bus_rsp_t             ram_rsp;
  bus_req_t             timer_req;
  bus_rsp_t             timer_rsp;
  logic [IRQ_LINES-1:0] irq_vec;

  cpu_bus cpu_bus_i (
    .clk     (clk),
    .rst     (rst),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .irq_vec (irq_vec),
    .cpu_irq (cpu_irq)
  );

  bus_decoder bus_decoder_i (
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .ram_req   (ram_req),
    .ram_rsp   (ram_rsp),
    .timer_req (timer_req),
    .timer_rsp (timer_rsp)
  );

  word_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) word_ram_i (
    .clk (clk),
    .rst (rst),
    .req (ram_req),
    .rsp (ram_rsp)
  );

  tick_timer #(
    .TIMER_IRQ (TIMER_IRQ)
  ) tick_timer_i (
    .clk     (clk),
    .rst     (rst),
    .req     (timer_req),
    .rsp     (timer_rsp),
    .irq_vec (irq_vec)
  );

endmodule

// ==== source/tick_timer.sv ====
// Periodic timer. Count wraps to zero when it equals the divisor and sets
// pending. Only interrupt line TIMER_IRQ is driven, the others stay low.
`timescale 1ns/1ps

module tick_timer
  import bus_pkg::*;
  import map_pkg::*;
#(
  parameter int TIMER_IRQ = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  bus_req_t             req,
  output bus_rsp_t             rsp,
  output logic [IRQ_LINES-1:0] irq_vec
);

  timer_reg_t  reg_sel;
  logic        wr;
  logic [1:0]  ctrl;
  logic [31:0] divisor;
  logic [31:0] count;
  logic        pending;
  logic        wrap;

  assign reg_sel = timer_reg_t'(req.addr[1:0]);
  assign wr      = req.stb && req.we;
  assign wrap    = ctrl[CTRL_EN_BIT] && (count == divisor);

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl    <= 2'b00;
      divisor <= 32'h0;
      count   <= 32'h0;
      pending <= 1'b0;
    end else begin
      if (wr && reg_sel == TMR_CTRL) begin
        ctrl <= req.wdata[1:0];
      end
      if (wr && reg_sel == TMR_DIVISOR) begin
        divisor <= req.wdata;
      end
      if (wrap) begin
        count <= 32'h0;
      end else if (ctrl[CTRL_EN_BIT]) begin
        count <= count + 32'd1;
      end
      // a new wrap wins over a clear in the same cycle
      if (wrap) begin
        pending <= 1'b1;
      end else if (wr && reg_sel == TMR_STATUS && req.wdata[0]) begin
        pending <= 1'b0;
      end
    end
  end

  always_comb begin
    case (reg_sel)
      TMR_CTRL:    rsp.rdata = {30'h0, ctrl};
      TMR_DIVISOR: rsp.rdata = divisor;
      TMR_COUNT:   rsp.rdata = count;
      default:     rsp.rdata = {31'h0, pending};
    endcase
    rsp.ack = req.stb;
  end

  always_comb begin
    irq_vec            = '0;
    irq_vec[TIMER_IRQ] = pending && ctrl[CTRL_IRQ_BIT];
  end

endmodule

// ==== source/word_ram.sv ====
// Word RAM with one wait state per transfer. The index is the low word
// address bits, so the array repeats in its region. Contents start undefined.
`timescale 1ns/1ps

module word_ram
  import bus_pkg::*;
#(
  parameter int RAM_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t req,
  output bus_rsp_t rsp
);

  localparam int ADDR_BITS = $clog2(RAM_WORDS);

  logic [31:0]          mem [RAM_WORDS];
  logic [ADDR_BITS-1:0] index;
  logic                 ack_q;
  logic [31:0]          rdata_q;

  assign index = req.addr[ADDR_BITS-1:0];

  // ack toggles while stb is held, giving two cycles per transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req.stb && !ack_q;
    end
  end

  always_ff @(posedge clk) begin
    if (req.stb && !ack_q) begin
      rdata_q <= mem[index];
    end
    // write lands on the acked edge
    if (req.stb && req.we && ack_q) begin
      mem[index] <= req.wdata;
    end
  end

  assign rsp = '{rdata: rdata_q, ack: ack_q};

endmodule

// ==== source/bus_decoder.sv ====
// Routes word bus cycles by address region. Unmapped cycles are acked
// at once with zero data and have no other effect.
`timescale 1ns/1ps

module bus_decoder
  import bus_pkg::*;
  import map_pkg::*;
(
  input  bus_req_t bus_req,
  output bus_rsp_t bus_rsp,
  output bus_req_t ram_req,
  input  bus_rsp_t ram_rsp,
  output bus_req_t timer_req,
  input  bus_rsp_t timer_rsp
);

  region_t region;

  // word address bits 29:26 are byte address bits 31:28
  assign region = region_of(bus_req.addr[29:26]);

  always_comb begin
    ram_req       = bus_req;
    ram_req.stb   = bus_req.stb && (region == REGION_RAM);
    timer_req     = bus_req;
    timer_req.stb = bus_req.stb && (region == REGION_TIMER);
  end

  always_comb begin
    case (region)
      REGION_RAM:   bus_rsp = ram_rsp;
      REGION_TIMER: bus_rsp = timer_rsp;
      default: begin
        bus_rsp.rdata = 32'h0;
        bus_rsp.ack   = bus_req.stb;
      end
    endcase
  end

endmodule

// ==== source/cpu_bus.sv ====
// Turns sized CPU accesses into word bus cycles. Sub-word writes take a
// read phase and a write-back phase. Low address bits beyond the access
// size are ignored, so misaligned accesses are not detected.
`timescale 1ns/1ps

module cpu_bus
  import bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_req_t             cpu_req,
  output cpu_rsp_t             cpu_rsp,
  output bus_req_t             bus_req,
  input  bus_rsp_t             bus_rsp,
  input  logic [IRQ_LINES-1:0] irq_vec,
  output logic [IRQ_LINES-1:0] cpu_irq
);

  typedef enum logic {
    IDLE_OR_READ,
    WRITE_BACK
  } state_t;

  state_t      state;
  state_t      next_state;
  logic        sub_word;
  logic [31:0] rdata_ext;
  logic [31:0] merged;
  logic [31:0] wbuf;
  logic        wbuf_we;

  assign sub_word = (cpu_req.size != SIZE_WORD);

  // read lane select with zero extension
  always_comb begin
    case (cpu_req.size)
      SIZE_BYTE: begin
        case (cpu_req.addr[1:0])
          2'd0:    rdata_ext = {24'h0, bus_rsp.rdata[31:24]};
          2'd1:    rdata_ext = {24'h0, bus_rsp.rdata[23:16]};
          2'd2:    rdata_ext = {24'h0, bus_rsp.rdata[15:8]};
          default: rdata_ext = {24'h0, bus_rsp.rdata[7:0]};
        endcase
      end
      SIZE_HALF: begin
        if (cpu_req.addr[1]) begin
          rdata_ext = {16'h0, bus_rsp.rdata[15:0]};
        end else begin
          rdata_ext = {16'h0, bus_rsp.rdata[31:16]};
        end
      end
      default: rdata_ext = bus_rsp.rdata;
    endcase
  end

  // new lane merged into the word just read
  always_comb begin
    merged = bus_rsp.rdata;
    if (cpu_req.size == SIZE_BYTE) begin
      case (cpu_req.addr[1:0])
        2'd0:    merged[31:24] = cpu_req.wdata[7:0];
        2'd1:    merged[23:16] = cpu_req.wdata[7:0];
        2'd2:    merged[15:8]  = cpu_req.wdata[7:0];
        default: merged[7:0]   = cpu_req.wdata[7:0];
      endcase
    end else if (cpu_req.addr[1]) begin
      merged[15:0] = cpu_req.wdata[15:0];
    end else begin
      merged[31:16] = cpu_req.wdata[15:0];
    end
  end

  always_comb begin
    bus_req.stb   = 1'b0;
    bus_req.we    = 1'b0;
    bus_req.addr  = cpu_req.addr[31:2];
    bus_req.wdata = cpu_req.wdata;
    cpu_rsp.rdata = rdata_ext;
    cpu_rsp.ack   = 1'b0;
    wbuf_we       = 1'b0;
    next_state    = state;
    case (state)
      IDLE_OR_READ: begin
        if (cpu_req.stb) begin
          bus_req.stb = 1'b1;
          if (cpu_req.we && sub_word) begin
            // read phase, the CPU is not acked yet
            wbuf_we = bus_rsp.ack;
            if (bus_rsp.ack) begin
              next_state = WRITE_BACK;
            end
          end else begin
            bus_req.we  = cpu_req.we;
            cpu_rsp.ack = bus_rsp.ack;
          end
        end
      end
      WRITE_BACK: begin
        bus_req.stb   = 1'b1;
        bus_req.we    = 1'b1;
        bus_req.wdata = wbuf;
        cpu_rsp.ack   = bus_rsp.ack;
        if (bus_rsp.ack) begin
          next_state = IDLE_OR_READ;
        end
      end
      default: next_state = IDLE_OR_READ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE_OR_READ;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (wbuf_we) begin
      wbuf <= merged;
    end
  end

  assign cpu_irq = irq_vec;

endmodule

// ==== source/map_pkg.sv ====
// Address map. The region comes from byte address bits 31:28 only,
// so each target repeats inside its region.
package map_pkg;

  localparam logic [3:0] RAM_TAG   = 4'h0;
  localparam logic [3:0] TIMER_TAG = 4'hf;

  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_TIMER,
    REGION_NONE
  } region_t;

  // timer registers, indexed by byte address bits 3:2
  typedef enum logic [1:0] {
    TMR_CTRL    = 2'd0,
    TMR_DIVISOR = 2'd1,
    TMR_COUNT   = 2'd2,
    TMR_STATUS  = 2'd3
  } timer_reg_t;

  localparam int CTRL_EN_BIT  = 0;
  localparam int CTRL_IRQ_BIT = 1;

  function automatic region_t region_of(logic [3:0] tag);
    if (tag == RAM_TAG) begin
      return REGION_RAM;
    end else if (tag == TIMER_TAG) begin
      return REGION_TIMER;
    end
    return REGION_NONE;
  endfunction

endpackage

// ==== source/bus_pkg.sv ====
// CPU-side and word bus types shared by the adapter, the decoder and the targets.
// Lanes are big-endian, so byte offset 0 maps to bits 31:24.
package bus_pkg;

  localparam int IRQ_LINES = 16;

  // size[1] set means a full word
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_t;

  typedef struct packed {
    logic         stb;
    logic         we;
    access_size_t size;
    logic [31:0]  addr;
    logic [31:0]  wdata;
  } cpu_req_t;

  // rdata is zero-extended for sub-word reads
  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
  } cpu_rsp_t;

  // addr is a word address, byte address bits 31:2
  typedef struct packed {
    logic        stb;
    logic        we;
    logic [29:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
  } bus_rsp_t;

endpackage
